// ==== cl_ddr_ctl_top.sv ====
// DDR card control top level
`timescale 1ns/1ps
`default_nettype none

module cl_ddr_ctl_top
(
   input  logic                      clk,
   input  logic                      sync_rst_n,

   // Function level reset
   input  logic                      flr_assert,
   output logic                      flr_done,

   // Scrubber control and status
   input  logic [31:0]               ctl0,
   input  ddr_ctl_pkg::scrub_stat_t  scrub_stat [ddr_ctl_pkg::NUM_DDR],
   input  logic [2:0]                ready_lcl,
   input  logic                      ready_c,
   output logic [3:0]                scrub_en,
   output logic [31:0]               id0,
   output logic [31:0]               id1,
   output logic [3:0]                ddr_ready,
   output logic [3:0]                scrub_done,

   // Controller statistics ports
   input  ddr_ctl_pkg::stat_req_t    stat_req   [ddr_ctl_pkg::NUM_STAT_CH],
   output ddr_ctl_pkg::stat_req_t    stat_req_q [ddr_ctl_pkg::NUM_STAT_CH],
   input  ddr_ctl_pkg::stat_ack_t    stat_ack   [ddr_ctl_pkg::NUM_STAT_CH],
   output ddr_ctl_pkg::stat_ack_t    stat_ack_q [ddr_ctl_pkg::NUM_STAT_CH],

   // Channel handshake monitoring
   input  ddr_ctl_pkg::axi_fire_t    ddr_fire   [ddr_ctl_pkg::NUM_DDR],
   output ddr_ctl_pkg::traffic_cnt_t ddr_counts [ddr_ctl_pkg::NUM_DDR]
);

   // ----------------------------------------
   // FLR handling
   // ----------------------------------------

   flr_responder u_flr
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .flr_assert (flr_assert),
      .flr_done   (flr_done)
   );

   // ----------------------------------------
   // Scrubber control
   // ----------------------------------------

   scrub_ctl u_scrub
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .scrub_stat (scrub_stat),
      .ready_lcl  (ready_lcl),
      .ready_c    (ready_c),
      .scrub_en   (scrub_en),
      .id0        (id0),
      .id1        (id1),
      .ddr_ready  (ddr_ready),
      .scrub_done (scrub_done)
   );

   // ----------------------------------------
   // Statistics port pipelines
   // ----------------------------------------

   // Both directions are retimed by the same depth
   for (genvar g = 0; g < ddr_ctl_pkg::NUM_STAT_CH; g++)
   begin : g_stat
      stat_pipe #(.payload_t(ddr_ctl_pkg::stat_req_t)) u_req_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_bus     (stat_req[g]),
         .out_bus    (stat_req_q[g])
      );

      stat_pipe #(.payload_t(ddr_ctl_pkg::stat_ack_t)) u_ack_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_bus     (stat_ack[g]),
         .out_bus    (stat_ack_q[g])
      );

      // A controller accepts one access type per request
      a_stat_wr_rd_excl: assert property (
         @(posedge clk) disable iff (!sync_rst_n)
         !(stat_req[g].wr && stat_req[g].rd)
      );
   end

   // ----------------------------------------
   // Traffic counters
   // ----------------------------------------

   for (genvar c = 0; c < ddr_ctl_pkg::NUM_DDR; c++)
   begin : g_cnt
      ddr_traffic_counter u_cnt
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .fire       (ddr_fire[c]),
         .counts     (ddr_counts[c])
      );
   end

endmodule

`default_nettype wire

// ==== ddr_ctl_pkg.sv ====
// DDR card glue shared definitions
`default_nettype none

package ddr_ctl_pkg;

   // ----------------------------------------
   // Sizes
   // ----------------------------------------

   // Register stages on each statistics port, needed for timing closure
   localparam int unsigned NUM_STAT_STGS = 8;
   // Controllers that expose a statistics port
   localparam int unsigned NUM_STAT_CH = 3;
   // Memory channels A, B, C, D
   localparam int unsigned NUM_DDR = 4;

   localparam int unsigned STAT_ADDR_W = 8;
   localparam int unsigned STAT_DATA_W = 32;
   localparam int unsigned STAT_INT_W = 8;
   localparam int unsigned SCRB_ADDR_W = 64;
   localparam int unsigned CNT_W = 32;

   // ----------------------------------------
   // Control word layout
   // ----------------------------------------

   // Debug readback enable and memory select
   localparam int unsigned DBG_EN_BIT = 31;
   localparam int unsigned DBG_SEL_MSB = 30;
   localparam int unsigned DBG_SEL_LSB = 28;

   // Scrub enables; D and C are swapped relative to the channel letters
   localparam int unsigned SCRB_A = 0;
   localparam int unsigned SCRB_B = 1;
   localparam int unsigned SCRB_D = 2;
   localparam int unsigned SCRB_C = 3;

   // Card identifiers shown while debug readback is off
   localparam logic [31:0] CL_ID0 = 32'hC0DE_0001;
   localparam logic [31:0] CL_ID1 = 32'hC0DE_0002;

   // ----------------------------------------
   // Types
   // ----------------------------------------

   // Statistics request toward a controller
   typedef struct packed {
      logic                   wr;
      logic                   rd;
      logic [STAT_ADDR_W-1:0] addr;
      logic [STAT_DATA_W-1:0] wdata;
   } stat_req_t;

   // Statistics response from a controller
   typedef struct packed {
      logic                   ack;
      logic [STAT_INT_W-1:0]  intr;
      logic [STAT_DATA_W-1:0] rdata;
   } stat_ack_t;

   // Status reported by one scrubber
   typedef struct packed {
      logic                   done;
      logic [SCRB_ADDR_W-1:0] addr;
   } scrub_stat_t;

   // One-cycle handshake strobes of one channel
   typedef struct packed {
      logic aw;
      logic w;
      logic ar;
      logic r;
      logic b;
   } axi_fire_t;

   // Handshake event counts of one channel
   typedef struct packed {
      logic [CNT_W-1:0] aw_cnt;
      logic [CNT_W-1:0] w_cnt;
      logic [CNT_W-1:0] ar_cnt;
      logic [CNT_W-1:0] r_cnt;
      logic [CNT_W-1:0] b_cnt;
   } traffic_cnt_t;

endpackage

`default_nettype wire

// ==== ddr_traffic_counter.sv ====
// Channel traffic counters
`timescale 1ns/1ps
`default_nettype none

module ddr_traffic_counter
(
   input  logic                      clk,
   input  logic                      sync_rst_n,

   input  ddr_ctl_pkg::axi_fire_t    fire,
   output ddr_ctl_pkg::traffic_cnt_t counts
);

   // Each count advances on its own strobe and wraps silently
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         counts <= '0;
      end
      else
      begin
         // Write address and write data
         if (fire.aw)
         begin
            counts.aw_cnt <= counts.aw_cnt + 1'b1;
         end
         if (fire.w)
         begin
            counts.w_cnt <= counts.w_cnt + 1'b1;
         end

         // Read address and read data
         if (fire.ar)
         begin
            counts.ar_cnt <= counts.ar_cnt + 1'b1;
         end
         if (fire.r)
         begin
            counts.r_cnt <= counts.r_cnt + 1'b1;
         end

         // Write response
         if (fire.b)
         begin
            counts.b_cnt <= counts.b_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
ddr_ctl_pkg.sv
stat_pipe.sv
flr_responder.sv
scrub_ctl.sv
ddr_traffic_counter.sv
cl_ddr_ctl_top.sv
tb_cl_ddr_ctl.sv

// ==== flr_responder.sv ====
// Function level reset responder
`timescale 1ns/1ps
`default_nettype none

module flr_responder
(
   input  logic clk,
   input  logic sync_rst_n,

   input  logic flr_assert,
   output logic flr_done
);

   logic flr_assert_q;

   // Done follows the registered request but toggles against itself,
   // so a held request gives a pulse train and never a level
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   // Shell expects single-cycle done pulses
   a_flr_done_pulse: assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done
   );

endmodule

`default_nettype wire

// ==== scrub_ctl.sv ====
// Scrubber control and status
`timescale 1ns/1ps
`default_nettype none

module scrub_ctl
(
   input  logic                     clk,
   input  logic                     sync_rst_n,

   input  logic [31:0]              ctl0,
   input  ddr_ctl_pkg::scrub_stat_t scrub_stat [ddr_ctl_pkg::NUM_DDR],
   input  logic [2:0]               ready_lcl,
   input  logic                     ready_c,

   output logic [3:0]               scrub_en,
   output logic [31:0]              id0,
   output logic [31:0]              id1,
   output logic [3:0]               ddr_ready,
   output logic [3:0]               scrub_done
);

   logic [31:0] ctl0_q;
   logic        dbg_en;
   logic [ddr_ctl_pkg::DBG_SEL_MSB-ddr_ctl_pkg::DBG_SEL_LSB:0] dbg_sel;
   logic [ddr_ctl_pkg::SCRB_ADDR_W-1:0] sel_addr;
   logic        ready_c_q;

   // ----------------------------------------
   // Control word
   // ----------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl0_q <= 32'd0;
      end
      else
      begin
         ctl0_q <= ctl0;
      end
   end

   always_comb
   begin
      scrub_en                      = 4'd0;
      scrub_en[ddr_ctl_pkg::SCRB_A] = ctl0_q[ddr_ctl_pkg::SCRB_A];
      scrub_en[ddr_ctl_pkg::SCRB_B] = ctl0_q[ddr_ctl_pkg::SCRB_B];
      scrub_en[ddr_ctl_pkg::SCRB_D] = ctl0_q[ddr_ctl_pkg::SCRB_D];
      scrub_en[ddr_ctl_pkg::SCRB_C] = ctl0_q[ddr_ctl_pkg::SCRB_C];
   end

   assign dbg_en  = ctl0_q[ddr_ctl_pkg::DBG_EN_BIT];
   assign dbg_sel = ctl0_q[ddr_ctl_pkg::DBG_SEL_MSB:ddr_ctl_pkg::DBG_SEL_LSB];

   // ----------------------------------------
   // ID readback
   // ----------------------------------------

   // Unused select codes fall back to channel A
   always_comb
   begin
      case (dbg_sel)
         3'd1:    sel_addr = scrub_stat[ddr_ctl_pkg::SCRB_B].addr;
         3'd2:    sel_addr = scrub_stat[ddr_ctl_pkg::SCRB_D].addr;
         3'd3:    sel_addr = scrub_stat[ddr_ctl_pkg::SCRB_C].addr;
         default: sel_addr = scrub_stat[ddr_ctl_pkg::SCRB_A].addr;
      endcase
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= ddr_ctl_pkg::CL_ID0;
         id1 <= ddr_ctl_pkg::CL_ID1;
      end
      else if (dbg_en)
      begin
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[63:32];
      end
      else
      begin
         id0 <= ddr_ctl_pkg::CL_ID0;
         id1 <= ddr_ctl_pkg::CL_ID1;
      end
   end

   // ----------------------------------------
   // Status vectors
   // ----------------------------------------

   // Channel C readiness comes from the shell and is retimed here
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ready_c_q <= 1'b0;
      end
      else
      begin
         ready_c_q <= ready_c;
      end
   end

   assign ddr_ready  = {ready_lcl[2], ready_c_q, ready_lcl[1:0]};

   assign scrub_done = {scrub_stat[ddr_ctl_pkg::SCRB_C].done,
                        scrub_stat[ddr_ctl_pkg::SCRB_D].done,
                        scrub_stat[ddr_ctl_pkg::SCRB_B].done,
                        scrub_stat[ddr_ctl_pkg::SCRB_A].done};

   // Only four scrubbers exist, higher select codes are a software error
   a_dbg_sel_range: assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      dbg_en |-> (dbg_sel <= 3'd3)
   );

endmodule

`default_nettype wire

// ==== stat_pipe.sv ====
// Statistics register pipeline
`timescale 1ns/1ps
`default_nettype none

module stat_pipe #(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     sync_rst_n,

   input  payload_t in_bus,
   output payload_t out_bus
);

   // Stage 0 takes the input, the last stage drives the output
   payload_t stg [ddr_ctl_pkg::NUM_STAT_STGS];

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         // Strobes inside the payload must not fire out of reset
         for (int i = 0; i < ddr_ctl_pkg::NUM_STAT_STGS; i++)
         begin
            stg[i] <= '0;
         end
      end
      else
      begin
         stg[0] <= in_bus;
         for (int i = 1; i < ddr_ctl_pkg::NUM_STAT_STGS; i++)
         begin
            stg[i] <= stg[i-1];
         end
      end
   end

   assign out_bus = stg[ddr_ctl_pkg::NUM_STAT_STGS-1];

endmodule

`default_nettype wire

// ==== tb_cl_ddr_ctl.sv ====
// DDR card control testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cl_ddr_ctl;

   logic        clk;
   logic        sync_rst_n;
   logic        flr_assert;
   logic        flr_done;
   logic [31:0] ctl0;
   logic [2:0]  ready_lcl;
   logic        ready_c;
   logic [3:0]  scrub_en;
   logic [31:0] id0;
   logic [31:0] id1;
   logic [3:0]  ddr_ready;
   logic [3:0]  scrub_done;

   ddr_ctl_pkg::scrub_stat_t  scrub_stat [ddr_ctl_pkg::NUM_DDR];
   ddr_ctl_pkg::stat_req_t    stat_req   [ddr_ctl_pkg::NUM_STAT_CH];
   ddr_ctl_pkg::stat_req_t    stat_req_q [ddr_ctl_pkg::NUM_STAT_CH];
   ddr_ctl_pkg::stat_ack_t    stat_ack   [ddr_ctl_pkg::NUM_STAT_CH];
   ddr_ctl_pkg::stat_ack_t    stat_ack_q [ddr_ctl_pkg::NUM_STAT_CH];
   ddr_ctl_pkg::axi_fire_t    ddr_fire   [ddr_ctl_pkg::NUM_DDR];
   ddr_ctl_pkg::traffic_cnt_t ddr_counts [ddr_ctl_pkg::NUM_DDR];

   // Items sent into the pipelines by drive cycle
   ddr_ctl_pkg::stat_req_t req_hist [ddr_ctl_pkg::NUM_STAT_CH][256];
   ddr_ctl_pkg::stat_ack_t ack_hist [ddr_ctl_pkg::NUM_STAT_CH][256];

   // Reference counts in the order aw w ar r b
   logic [31:0] model_cnt [ddr_ctl_pkg::NUM_DDR][5];

   logic [959:0] rec_q [$];
   logic [15:0]  lfsr_state;
   logic         prev_ready_c;
   int           error_cnt;
   int           check_cnt;
   int           cycle_cnt;
   int           cycle_limit;

   cl_ddr_ctl_top u_dut
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .ctl0       (ctl0),
      .scrub_stat (scrub_stat),
      .ready_lcl  (ready_lcl),
      .ready_c    (ready_c),
      .scrub_en   (scrub_en),
      .id0        (id0),
      .id1        (id1),
      .ddr_ready  (ddr_ready),
      .scrub_done (scrub_done),
      .stat_req   (stat_req),
      .stat_req_q (stat_req_q),
      .stat_ack   (stat_ack),
      .stat_ack_q (stat_ack_q),
      .ddr_fire   (ddr_fire),
      .ddr_counts (ddr_counts)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial
   begin
      wait (cycle_limit > 0 && cycle_cnt >= cycle_limit);
      $display("Timeout after %0d cycles, the directed tests did not complete", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic next_lfsr_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r = {r[62:0], next_lfsr_bit()};
      end
      return r;
   endfunction

   // Fixed scrubber addresses with distinct halves per channel
   function automatic logic [63:0] scrub_addr(input int idx);
      case (idx)
         1:       return 64'hB0B0_0002_5A5A_000B;
         2:       return 64'hD0D0_0003_5A5A_000D;
         3:       return 64'hC0C0_0004_5A5A_000C;
         default: return 64'hA0A0_0001_5A5A_000A;
      endcase
   endfunction

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      check_cnt++;
      if (actual !== expected)
      begin
         error_cnt++;
         $display("** Error @ %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic compare_counts();
      for (int ch = 0; ch < ddr_ctl_pkg::NUM_DDR; ch++)
      begin
         check_value(ddr_counts[ch].aw_cnt, model_cnt[ch][0], $sformatf("ch %0d aw", ch));
         check_value(ddr_counts[ch].w_cnt, model_cnt[ch][1], $sformatf("ch %0d w", ch));
         check_value(ddr_counts[ch].ar_cnt, model_cnt[ch][2], $sformatf("ch %0d ar", ch));
         check_value(ddr_counts[ch].r_cnt, model_cnt[ch][3], $sformatf("ch %0d r", ch));
         check_value(ddr_counts[ch].b_cnt, model_cnt[ch][4], $sformatf("ch %0d b", ch));
      end
   endtask

   // Cycles a record takes for the run limit
   function automatic int record_cycles(input logic [959:0] line);
      logic [63:0] op;
      int          v;
      void'($sscanf(line, "%s %d", op, v));
      if (op == "FLR")
         return v + 4;
      else if (op == "STAT")
         return v + 8;
      else if (op == "FIRE")
         return v + 1;
      else
         return 3;
   endfunction

   // ----------------------------------------
   // Record handlers
   // ----------------------------------------

   task automatic apply_ctl_word(input logic [959:0] line);
      logic [63:0] op;
      logic [31:0] f_ctl, f_done, f_rl, f_rc;
      logic [31:0] e_en, e_id0, e_id1, e_rdy, e_done;
      int          n;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", op, f_ctl, f_done, f_rl, f_rc,
                  e_en, e_id0, e_id1, e_rdy, e_done);
      if (n != 10)
      begin
         error_cnt++;
         $display("Malformed CTL record in the input file");
      end
      else
      begin
         @(negedge clk);
         ctl0      = f_ctl;
         ready_lcl = f_rl[2:0];
         ready_c   = f_rc[0];
         for (int i = 0; i < ddr_ctl_pkg::NUM_DDR; i++)
         begin
            scrub_stat[i].done = f_done[i];
         end
         // Retimed ready_c still shows the old level
         #1;
         check_value(ddr_ready[2], prev_ready_c, "ddr_ready[2] before retime");
         prev_ready_c = f_rc[0];
         @(posedge clk);
         @(negedge clk);
         check_value(scrub_en, e_en, "scrub_en");
         check_value(ddr_ready, e_rdy, "ddr_ready");
         check_value(scrub_done, e_done, "scrub_done");
         @(posedge clk);
         @(negedge clk);
         check_value(id0, e_id0, "id0");
         check_value(id1, e_id1, "id1");
      end
   endtask

   task automatic hold_flr_request(input logic [959:0] line);
      logic [63:0] op;
      logic [31:0] pat;
      int          hold;
      int          len;
      void'($sscanf(line, "%s %d %b", op, hold, pat));
      len = hold + 3;
      @(negedge clk);
      flr_assert = 1'b1;
      for (int k = 1; k <= len; k++)
      begin
         @(posedge clk);
         @(negedge clk);
         check_value(flr_done, pat[len-k], $sformatf("flr_done cycle %0d", k));
         if (k == hold)
         begin
            flr_assert = 1'b0;
         end
      end
   endtask

   task automatic stream_stat_items(input int n);
      logic [63:0] r;
      for (int t = 0; t < n + 8; t++)
      begin
         @(negedge clk);
         for (int ch = 0; ch < ddr_ctl_pkg::NUM_STAT_CH; ch++)
         begin
            if (t >= 8)
            begin
               check_value(stat_req_q[ch], req_hist[ch][t-8], $sformatf("stat_req_q[%0d]", ch));
               check_value(stat_ack_q[ch], ack_hist[ch][t-8], $sformatf("stat_ack_q[%0d]", ch));
            end
            if (t < n)
            begin
               r = rand_bits($bits(ddr_ctl_pkg::stat_req_t));
               req_hist[ch][t] = r[$bits(ddr_ctl_pkg::stat_req_t)-1:0];
               // Write and read never share a request
               if (req_hist[ch][t].wr)
               begin
                  req_hist[ch][t].rd = 1'b0;
               end
               r = rand_bits($bits(ddr_ctl_pkg::stat_ack_t));
               ack_hist[ch][t] = r[$bits(ddr_ctl_pkg::stat_ack_t)-1:0];
               stat_req[ch]    = req_hist[ch][t];
               stat_ack[ch]    = ack_hist[ch][t];
            end
            else
            begin
               stat_req[ch] = '0;
               stat_ack[ch] = '0;
            end
         end
      end
   endtask

   task automatic count_fire_strobes(input int n);
      logic [63:0] r;
      for (int t = 0; t < n; t++)
      begin
         @(negedge clk);
         for (int ch = 0; ch < ddr_ctl_pkg::NUM_DDR; ch++)
         begin
            r = rand_bits(5);
            ddr_fire[ch] = r[4:0];
            for (int k = 0; k < 5; k++)
            begin
               model_cnt[ch][k] = model_cnt[ch][k] + r[4-k];
            end
         end
      end
      @(negedge clk);
      for (int ch = 0; ch < ddr_ctl_pkg::NUM_DDR; ch++)
      begin
         ddr_fire[ch] = '0;
      end
      compare_counts();
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------

   initial
   begin
      integer       fd;
      int           n;
      int           total;
      logic [959:0] line;
      logic [63:0]  op;

      sync_rst_n   = 1'b0;
      // Busy inputs while reset is held
      flr_assert   = 1'b1;
      ctl0         = 32'h8000_000F;
      ready_lcl    = 3'd0;
      ready_c      = 1'b1;
      prev_ready_c = 1'b0;
      lfsr_state   = 16'd23741;
      error_cnt    = 0;
      check_cnt    = 0;
      cycle_cnt    = 0;
      cycle_limit  = 0;
      total        = 0;
      for (int i = 0; i < ddr_ctl_pkg::NUM_DDR; i++)
      begin
         scrub_stat[i].done = 1'b0;
         scrub_stat[i].addr = scrub_addr(i);
         ddr_fire[i]        = '0;
         for (int k = 0; k < 5; k++)
         begin
            model_cnt[i][k] = 32'd0;
         end
      end
      for (int ch = 0; ch < ddr_ctl_pkg::NUM_STAT_CH; ch++)
      begin
         stat_req[ch]    = '1;
         stat_req[ch].rd = 1'b0;
         stat_ack[ch]    = '1;
      end

      fd = $fopen("tb_cl_ddr_ctl_input.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file tb_cl_ddr_ctl_input.txt");
         $display("SIMULATION FAILED");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = '0;
            n    = $fgets(line, fd);
            op   = '0;
            // Comment lines start with a lone hash token
            if (n > 0 && $sscanf(line, "%s", op) == 1 && op != "#")
            begin
               rec_q.push_back(line);
               total += record_cycles(line);
            end
         end
         $fclose(fd);
         cycle_limit = 2 * total + 200;

         repeat (8) @(posedge clk);
         @(negedge clk);
         sync_rst_n = 1'b1;
         flr_assert = 1'b0;
         ctl0       = 32'd0;
         ready_c    = 1'b0;
         for (int ch = 0; ch < ddr_ctl_pkg::NUM_STAT_CH; ch++)
         begin
            stat_req[ch] = '0;
            stat_ack[ch] = '0;
         end

         // Reset values
         for (int ch = 0; ch < ddr_ctl_pkg::NUM_STAT_CH; ch++)
         begin
            check_value(stat_req_q[ch], 64'd0, "stat_req_q after reset");
            check_value(stat_ack_q[ch], 64'd0, "stat_ack_q after reset");
         end
         check_value(flr_done, 1'b0, "flr_done after reset");
         check_value(scrub_en, 4'd0, "scrub_en after reset");
         check_value(id0, ddr_ctl_pkg::CL_ID0, "id0 after reset");
         check_value(id1, ddr_ctl_pkg::CL_ID1, "id1 after reset");
         check_value(ddr_ready, 4'd0, "ddr_ready after reset");
         compare_counts();

         foreach (rec_q[i])
         begin
            void'($sscanf(rec_q[i], "%s %d", op, n));
            if (op == "CTL")
               apply_ctl_word(rec_q[i]);
            else if (op == "FLR")
               hold_flr_request(rec_q[i]);
            else if (op == "STAT")
               stream_stat_items(n);
            else if (op == "FIRE")
               count_fire_strobes(n);
            else
            begin
               error_cnt++;
               $display("Unknown record type in record %0d of the input file", i);
            end
         end

         $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
         if (error_cnt == 0)
            $display("SIMULATION PASSED");
         else
            $display("SIMULATION FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tb_cl_ddr_ctl_input.txt ====
# CTL ctl0 done_in ready_lcl ready_c exp_en exp_id0 exp_id1 exp_ddr_ready exp_scrub_done
# FLR hold_cycles flr_done_bits, STAT item_count, FIRE cycle_count
STAT 12
CTL 00000000 0 0 0 0 C0DE0001 C0DE0002 0 0
CTL 00000001 1 1 0 1 C0DE0001 C0DE0002 1 1
CTL 00000002 2 2 1 2 C0DE0001 C0DE0002 6 2
CTL 00000004 4 4 0 4 C0DE0001 C0DE0002 8 4
CTL 00000008 8 7 1 8 C0DE0001 C0DE0002 F 8
CTL 0000000F F 3 0 F C0DE0001 C0DE0002 3 F
CTL 80000000 0 0 0 0 5A5A000A A0A00001 0 0
CTL 90000003 1 5 1 3 5A5A000B B0B00002 D 1
CTL A0000000 0 0 0 0 5A5A000D D0D00003 0 0
CTL B0000005 0 0 0 5 5A5A000C C0C00004 0 0
CTL 7000000A 0 0 0 A C0DE0001 C0DE0002 0 0
FLR 6 010101000
FLR 5 01010100
FLR 1 0100
STAT 3
FIRE 20
CTL 00000000 0 0 0 0 C0DE0001 C0DE0002 0 0
FIRE 40
STAT 20
